// File: design/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opJ     = 6'h02;
    localparam opcode_t opBeq   = 6'h04;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSw    = 6'h2b;

    // funct field of R-type
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr  = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    typedef enum logic [3:0] {
        aluAnd = 4'd0,
        aluOr  = 4'd1,
        aluAdd = 4'd2,
        aluSub = 4'd6,
        aluSlt = 4'd7
    } aluCtrl_t;

    typedef enum logic [3:0] {
        stFetch, stDecode, stMemAddr, stMemRead, stMemWriteBack, stMemWrite,
        stExecute, stRTypeDone, stAddiDone, stBranch, stJump
    } ctrlState_t;

    typedef struct packed {
        logic [1:0] pcWriteCond;
        logic       pcWrite;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       irWrite;
        logic [1:0] pcSource;
        logic [1:0] aluOp;
        logic [1:0] aluSrcB;
        logic       aluSrcA;
        logic       regWrite;
        logic       regDst;
    } ctrlSignals_t;

endpackage

// File: design/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  logic [1:0]     aluOp,
    input  cpuPkg::funct_t funct,
    input  cpuPkg::word_t  leftOperand,
    input  cpuPkg::word_t  rightOperand,
    output cpuPkg::word_t  aluResult,
    output logic           zero
);
    import cpuPkg::*;

    aluCtrl_t aluCtrl;

    // 00 add, 01 subtract, 10 from funct
    always_comb begin
        case (aluOp)
            2'b00: aluCtrl = aluAdd;
            2'b01: aluCtrl = aluSub;
            2'b10: begin
                case (funct)
                    fnAdd: aluCtrl = aluAdd;
                    fnSub: aluCtrl = aluSub;
                    fnAnd: aluCtrl = aluAnd;
                    fnOr: aluCtrl = aluOr;
                    fnSlt: aluCtrl = aluSlt;
                    default: aluCtrl = aluAdd;
                endcase
            end
            default: aluCtrl = aluAdd;
        endcase
    end

    always_comb begin
        case (aluCtrl)
            aluAnd: aluResult = leftOperand & rightOperand;
            aluOr: aluResult = leftOperand | rightOperand;
            aluSub: aluResult = leftOperand - rightOperand;
            // signed compare
            aluSlt: aluResult = word_t'($signed(leftOperand) < $signed(rightOperand));
            default: aluResult = leftOperand + rightOperand;
        endcase
    end

    assign zero = (aluResult == '0);

endmodule

// File: design/multiCycleControl.sv
`timescale 1ns/10ps

module multiCycleControl (
    input  logic                 clk,
    input  logic                 rst,
    input  cpuPkg::opcode_t      opcode,
    output cpuPkg::ctrlSignals_t ctrl,
    output cpuPkg::ctrlState_t   state
);
    import cpuPkg::*;

    ctrlState_t nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // opcode only matters after decode and after the address calculation
    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: nextState = stDecode;
            stDecode: begin
                case (opcode)
                    opRType: nextState = stExecute;
                    opLw, opSw, opAddi: nextState = stMemAddr;
                    opBeq: nextState = stBranch;
                    opJ: nextState = stJump;
                    default: nextState = stFetch;
                endcase
            end
            stMemAddr: begin
                case (opcode)
                    opLw: nextState = stMemRead;
                    opSw: nextState = stMemWrite;
                    default: nextState = stAddiDone;
                endcase
            end
            stMemRead: nextState = stMemWriteBack;
            stExecute: nextState = stRTypeDone;
            default: nextState = stFetch;
        endcase
    end

    // Moore outputs, everything not listed stays low
    always_comb begin
        ctrl = '0;
        case (state)
            stFetch: begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
                // pc + 4
                ctrl.aluSrcB = 2'b01;
                ctrl.pcWrite = 1'b1;
            end
            stDecode: begin
                // branch target lands in aluOut
                ctrl.aluSrcB = 2'b11;
            end
            stMemAddr: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10;
            end
            stMemRead: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD = 1'b1;
            end
            stMemWriteBack: begin
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            stMemWrite: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD = 1'b1;
            end
            stExecute: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluOp = 2'b10;
            end
            stRTypeDone: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            stAddiDone: ctrl.regWrite = 1'b1;
            stBranch: begin
                // compare A and B, take aluOut as target on equal
                ctrl.aluSrcA = 1'b1;
                ctrl.aluOp = 2'b01;
                ctrl.pcWriteCond = 2'b01;
                ctrl.pcSource = 2'b01;
            end
            stJump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSource = 2'b10;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: design/multiCycleCpu.sv
`timescale 1ns/10ps

module multiCycleCpu #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic               clk,
    input  logic               rst,
    output cpuPkg::word_t      memAddr,
    output logic               memRead,
    output logic               memWrite,
    output cpuPkg::word_t      storeData,
    input  cpuPkg::word_t      freshMemoryReadData,
    output cpuPkg::regAddr_t   readRegister1,
    output cpuPkg::regAddr_t   readRegister2,
    output cpuPkg::regAddr_t   writeRegister,
    output cpuPkg::word_t      registerWriteData,
    output logic               regWrite,
    input  cpuPkg::word_t      freshRegisterReadData1,
    input  cpuPkg::word_t      freshRegisterReadData2,
    output cpuPkg::word_t      instruction,
    output cpuPkg::word_t      pcOut,
    output cpuPkg::ctrlState_t state
);
    import cpuPkg::*;

    ctrlSignals_t ctrl;
    word_t memDataReg;
    word_t regA;
    word_t regB;
    word_t aluOut;
    word_t extImm;
    word_t shiftedImm;
    word_t jumpAddr;
    word_t srcA;
    word_t srcB;
    word_t freshAluOut;
    word_t nextPc;
    logic  aluZero;
    logic  pcWriteEn;

    multiCycleControl control (
        .clk(clk),
        .rst(rst),
        .opcode(instruction[31:26]),
        .ctrl(ctrl),
        .state(state)
    );

    // a taken beq writes on zero, bit 1 would write on nonzero
    assign pcWriteEn = (aluZero & ctrl.pcWriteCond[0]) | (~aluZero & ctrl.pcWriteCond[1])
                     | ctrl.pcWrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcOut <= resetPc;
        end else if (pcWriteEn) begin
            pcOut <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            instruction <= freshMemoryReadData;
        end
    end

    // stage registers load every cycle
    always_ff @(posedge clk) begin
        memDataReg <= freshMemoryReadData;
        regA <= freshRegisterReadData1;
        regB <= freshRegisterReadData2;
        aluOut <= freshAluOut;
    end

    assign readRegister1 = instruction[25:21];
    assign readRegister2 = instruction[20:16];

    assign extImm = {{16{instruction[15]}}, instruction[15:0]};
    assign shiftedImm = {extImm[29:0], 2'b00};
    assign jumpAddr = {pcOut[31:28], instruction[25:0], 2'b00};

    assign srcA = ctrl.aluSrcA ? regA : pcOut;

    always_comb begin
        case (ctrl.aluSrcB)
            2'b00: srcB = regB;
            2'b01: srcB = 32'd4;
            2'b10: srcB = extImm;
            default: srcB = shiftedImm;
        endcase
    end

    aluUnit alu (
        .aluOp(ctrl.aluOp),
        .funct(instruction[5:0]),
        .leftOperand(srcA),
        .rightOperand(srcB),
        .aluResult(freshAluOut),
        .zero(aluZero)
    );

    always_comb begin
        case (ctrl.pcSource)
            2'b00: nextPc = freshAluOut;
            2'b01: nextPc = aluOut;
            2'b10: nextPc = jumpAddr;
            default: nextPc = '0;
        endcase
    end

    assign memAddr = ctrl.iorD ? aluOut : pcOut;
    assign storeData = regB;
    assign memRead = ctrl.memRead;
    assign memWrite = ctrl.memWrite;

    // rd for R-type, rt otherwise
    assign writeRegister = ctrl.regDst ? instruction[15:11] : instruction[20:16];
    assign registerWriteData = ctrl.memToReg ? memDataReg : aluOut;
    assign regWrite = ctrl.regWrite;

endmodule

// File: design/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic             clk,
    input  cpuPkg::regAddr_t readRegister1,
    input  cpuPkg::regAddr_t readRegister2,
    input  cpuPkg::regAddr_t writeRegister,
    input  cpuPkg::word_t    writeData,
    input  logic             regWrite,
    output cpuPkg::word_t    readData1,
    output cpuPkg::word_t    readData2
);
    import cpuPkg::*;

    word_t regs [32];

    // $zero never takes a write
    always_ff @(posedge clk) begin
        if (regWrite && writeRegister != '0) begin
            regs[writeRegister] <= writeData;
        end
    end

    assign readData1 = (readRegister1 == '0) ? '0 : regs[readRegister1];
    assign readData2 = (readRegister2 == '0) ? '0 : regs[readRegister2];

endmodule

// File: design/unifiedMemory.sv
`timescale 1ns/10ps

module unifiedMemory #(
    parameter int memWords = 256
) (
    input  logic          clk,
    input  cpuPkg::word_t addr,
    input  cpuPkg::word_t writeData,
    input  logic          memWrite,
    input  logic          loadEn,
    input  cpuPkg::word_t loadAddr,
    input  cpuPkg::word_t loadData,
    output cpuPkg::word_t readData
);
    import cpuPkg::*;

    localparam int idxBits = (memWords > 1) ? $clog2(memWords) : 1;

    word_t mem [memWords];
    logic [idxBits-1:0] coreIdx;
    logic [idxBits-1:0] loadIdx;

    // byte address to word index, wrapping at the depth
    assign coreIdx = idxBits'((addr >> 2) % memWords);
    assign loadIdx = idxBits'((loadAddr >> 2) % memWords);

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end else if (memWrite) begin
            mem[coreIdx] <= writeData;
        end
    end

    assign readData = mem[coreIdx];

endmodule

// File: design/cpuSystem.sv
`timescale 1ns/10ps

module cpuSystem #(
    parameter int            memWords = 256,
    parameter cpuPkg::word_t resetPc  = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               loadEn,
    input  cpuPkg::word_t      loadAddr,
    input  cpuPkg::word_t      loadData,
    output cpuPkg::word_t      pcOut,
    output cpuPkg::word_t      instruction,
    output cpuPkg::ctrlState_t state,
    output logic               regWrite,
    output cpuPkg::regAddr_t   writeRegister,
    output cpuPkg::word_t      registerWriteData,
    output logic               memWrite,
    output cpuPkg::word_t      memAddr,
    output cpuPkg::word_t      storeData
);
    import cpuPkg::*;

    word_t    memReadData;
    word_t    regData1;
    word_t    regData2;
    regAddr_t readRegister1;
    regAddr_t readRegister2;

    // memory reads are combinational, so the read strobe stays inside the core
    multiCycleCpu #(
        .resetPc(resetPc)
    ) core (
        .clk(clk),
        .rst(rst),
        .memAddr(memAddr),
        .memRead(),
        .memWrite(memWrite),
        .storeData(storeData),
        .freshMemoryReadData(memReadData),
        .readRegister1(readRegister1),
        .readRegister2(readRegister2),
        .writeRegister(writeRegister),
        .registerWriteData(registerWriteData),
        .regWrite(regWrite),
        .freshRegisterReadData1(regData1),
        .freshRegisterReadData2(regData2),
        .instruction(instruction),
        .pcOut(pcOut),
        .state(state)
    );

    regFile registers (
        .clk(clk),
        .readRegister1(readRegister1),
        .readRegister2(readRegister2),
        .writeRegister(writeRegister),
        .writeData(registerWriteData),
        .regWrite(regWrite),
        .readData1(regData1),
        .readData2(regData2)
    );

    unifiedMemory #(
        .memWords(memWords)
    ) memory (
        .clk(clk),
        .addr(memAddr),
        .writeData(storeData),
        .memWrite(memWrite),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .readData(memReadData)
    );

endmodule

// File: verif/cpuSystem_sva.sv
`timescale 1ns/10ps

module cpuSystemSva (
    input logic                 clk,
    input logic                 rst,
    input cpuPkg::ctrlSignals_t ctrl,
    input cpuPkg::ctrlState_t   state
);
    import cpuPkg::*;

    // count of failed assertions
    int unsigned failCount = 0;

    // instruction register loads only during fetch
    irWriteOnlyInFetch: assert property (
        @(posedge clk) disable iff (rst) ctrl.irWrite |-> state == stFetch
    ) else begin
        $error("irWrite high outside stFetch");
        failCount++;
    end

    // one write strobe at a time
    singleWriteStrobe: assert property (
        @(posedge clk) disable iff (rst) !(ctrl.regWrite && ctrl.memWrite)
    ) else begin
        $error("regWrite and memWrite high together");
        failCount++;
    end

    // a write always ends its instruction
    fetchAfterWrite: assert property (
        @(posedge clk) disable iff (rst) (ctrl.regWrite || ctrl.memWrite) |=> state == stFetch
    ) else begin
        $error("state is not stFetch after a write cycle");
        failCount++;
    end

endmodule

bind multiCycleCpu cpuSystemSva controlChecks (
    .clk(clk),
    .rst(rst),
    .ctrl(ctrl),
    .state(state)
);

// File: verif/cpuSystemTb.sv
`timescale 1ns/10ps

module cpuSystemTb;
    import cpuPkg::*;

    localparam int    memWords    = 256;
    localparam word_t resetPc     = 32'h0;
    localparam int    clkPeriod   = 20;
    localparam int    fileDepth   = 192;
    localparam int    quietCycles = 20;

    // one expected register write or store
    typedef struct packed {
        logic  isStore;
        word_t addr;
        word_t data;
    } writeEvent_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       loadEn;
    word_t      loadAddr;
    word_t      loadData;
    word_t      pcOut;
    word_t      instruction;
    ctrlState_t state;
    logic       regWrite;
    regAddr_t   writeRegister;
    word_t      registerWriteData;
    logic       memWrite;
    word_t      memAddr;
    word_t      storeData;

    word_t       fileWords [fileDepth];
    word_t       progAddr [$];
    word_t       progWord [$];
    writeEvent_t expected [$];
    int          timeoutCycles;
    bit          running = 1'b0;

    cpuSystem #(
        .memWords(memWords),
        .resetPc(resetPc)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .pcOut(pcOut),
        .instruction(instruction),
        .state(state),
        .regWrite(regWrite),
        .writeRegister(writeRegister),
        .registerWriteData(registerWriteData),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .storeData(storeData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // each record is three words of kind, address or register, and value
    task automatic readInputFile();
        int idx;
        writeEvent_t ev;
        idx = 0;
        $readmemh("verif/program_input.txt", fileWords);
        while (fileWords[idx] !== 32'hf) begin
            assert (idx + 2 < fileDepth) else failRun("input file has no end record");
            case (fileWords[idx])
                32'h1: begin
                    progAddr.push_back(fileWords[idx + 1]);
                    progWord.push_back(fileWords[idx + 2]);
                end
                32'h2, 32'h3: begin
                    ev.isStore = (fileWords[idx] == 32'h3);
                    ev.addr = fileWords[idx + 1];
                    ev.data = fileWords[idx + 2];
                    expected.push_back(ev);
                end
                default: failRun($sformatf("bad record kind %h at word %0d of the input file",
                                           fileWords[idx], idx));
            endcase
            idx += 3;
        end
    endtask

    task automatic checkWriteEvent();
        writeEvent_t ev;
        ev = expected.pop_front();
        if (ev.isStore) begin
            assert (memWrite && !regWrite) else
                failRun("a register write came where a store was expected");
            assert (memAddr == ev.addr) else
                failRun($sformatf("FAILED memAddr: expected %h, got %h", ev.addr, memAddr));
            assert (storeData == ev.data) else
                failRun($sformatf("FAILED storeData: expected %h, got %h", ev.data, storeData));
        end else begin
            assert (regWrite && !memWrite) else
                failRun("a store came where a register write was expected");
            assert (writeRegister == regAddr_t'(ev.addr)) else
                failRun($sformatf("FAILED writeRegister: expected %h, got %h",
                                  regAddr_t'(ev.addr), writeRegister));
            assert (registerWriteData == ev.data) else
                failRun($sformatf("FAILED registerWriteData: expected %h, got %h",
                                  ev.data, registerWriteData));
        end
    endtask

    // bound control checks count their failures
    always @(UUT.core.controlChecks.failCount) begin
        assert (UUT.core.controlChecks.failCount == 0) else
            failRun("an assertion on the core control signals failed");
    end

    initial begin
        rst = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        readInputFile();
        timeoutCycles = 5 * expected.size() + progWord.size() + 50;
        // program goes in through the load port while the core is held
        foreach (progWord[i]) begin
            @(posedge clk);
            #1;
            loadEn = 1'b1;
            loadAddr = progAddr[i];
            loadData = progWord[i];
        end
        @(posedge clk);
        #1;
        loadEn = 1'b0;
        // reset stays up for 4 cycles past the load
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        running = 1'b1;
        @(negedge clk);
        assert (state == stFetch) else
            failRun($sformatf("FAILED state: expected %h, got %h", stFetch, state));
        assert (pcOut == resetPc) else
            failRun($sformatf("FAILED pcOut: expected %h, got %h", resetPc, pcOut));
        assert (regWrite == 1'b0) else
            failRun($sformatf("FAILED regWrite: expected %h, got %h", 1'b0, regWrite));
        assert (memWrite == 1'b0) else
            failRun($sformatf("FAILED memWrite: expected %h, got %h", 1'b0, memWrite));
        // strobes are sampled mid-cycle and the write lands on the next rising edge
        while (expected.size() > 0) begin
            @(negedge clk);
            if (regWrite || memWrite) begin
                checkWriteEvent();
            end
        end
        // final self-jump should leave both strobes idle
        repeat (quietCycles) begin
            @(negedge clk);
            assert (!regWrite && !memWrite) else
                failRun($sformatf("a write beyond the expected list occurred at pc %h", pcOut));
        end
        // the last program word is the closing self-jump
        assert (instruction == progWord[progWord.size() - 1]) else
            failRun($sformatf("FAILED instruction: expected %h, got %h",
                              progWord[progWord.size() - 1], instruction));
        $display("Finished with no errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (running);
        repeat (timeoutCycles) #clkPeriod;
        failRun("timeout: the program did not complete its expected writes");
    end

endmodule

// File: sim.f
design/cpuPkg.sv
design/aluUnit.sv
design/multiCycleControl.sv
design/multiCycleCpu.sv
design/regFile.sv
design/unifiedMemory.sv
design/cpuSystem.sv
verif/cpuSystem_sva.sv
verif/cpuSystemTb.sv

// File: verif/program_input.txt
// kind, then address or register number, then value, all in hex
// kind 1 loads a program word, 2 expects a register write, 3 expects a store, f ends the list
1 00 2001000C // addi $1, $0, 12
1 04 2002FFFA // addi $2, $0, -6
1 08 00221820 // add $3, $1, $2
1 0C 00222022 // sub $4, $1, $2
1 10 00222824 // and $5, $1, $2
1 14 00223025 // or $6, $1, $2
1 18 0041382A // slt $7, $2, $1
1 1C 20090100 // addi $9, $0, 0x100
1 20 AD24FFF0 // sw $4, -16($9)
1 24 8D2AFFF0 // lw $10, -16($9)
1 28 10220001 // beq $1, $2, +1 not taken
1 2C 200B0001 // addi $11, $0, 1
1 30 11440001 // beq $10, $4, +1 taken
1 34 200C07FF // addi $12, $0, 0x7ff skipped
1 38 08000010 // j 0x40
1 3C 200D0055 // addi $13, $0, 0x55 skipped
1 40 2000002A // addi $0, $0, 0x2a
1 44 00018020 // add $16, $0, $1
1 48 08000012 // j 0x48
2 01 0000000C
2 02 FFFFFFFA
2 03 00000006
2 04 00000012
2 05 00000008
2 06 FFFFFFFE
2 07 00000001
2 09 00000100
3 F0 00000012
2 0A 00000012
2 0B 00000001
2 00 0000002A
2 10 0000000C // $0 reads back as zero
f 0 0
